// File: hdl/id_settings.svh
// RV64 with 32 integer registers and three downstream stages is assumed throughout
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

// data path and pc width
`define ID_XLEN 64

// fetched instruction word
`define ID_INST_WD 32

// register index width and count
`define ID_GPR_ADDR_WD 5
`define ID_GPR_NUM 32

// es, ms and ws destination compares
`define ID_HAZ_STAGES 3

// a width of 64 is what the immediate sign extension
// in the decoder is sized against
// keep ID_GPR_NUM equal to 2**ID_GPR_ADDR_WD

`endif

// File: hdl/id_pkg.sv
// shared types for the decode stage and only the kept RV64 integer subset has encodings here
`include "id_settings.svh"

package id_pkg;

  typedef logic [`ID_INST_WD-1:0] inst_t;
  typedef logic [`ID_XLEN-1:0] pc_t;
  typedef logic [`ID_XLEN-1:0] xdata_t;
  typedef logic [`ID_GPR_ADDR_WD-1:0] gpr_addr_t;

  // alu operation sent to execute
  typedef enum logic [1:0] {
    ALU_ADD    = 2'd0,
    ALU_SUB    = 2'd1,
    ALU_PASS_B = 2'd2
  } alu_op_e;

  typedef enum logic {
    SRC1_REG  = 1'b0,
    SRC1_ZERO = 1'b1 // lui
  } src1_sel_e;

  typedef enum logic {
    SRC2_REG = 1'b0,
    SRC2_IMM = 1'b1
  } src2_sel_e;

  typedef logic [2:0] br_func_t;

  localparam br_func_t F3_BEQ  = 3'b000;
  localparam br_func_t F3_BNE  = 3'b001;
  localparam br_func_t F3_BLT  = 3'b100;
  localparam br_func_t F3_BGE  = 3'b101;
  localparam br_func_t F3_BLTU = 3'b110;
  localparam br_func_t F3_BGEU = 3'b111;

  localparam logic [2:0] F3_ADD_SUB = 3'b000; // also addi
  localparam logic [6:0] F7_ADD     = 7'b0000000;
  localparam logic [6:0] F7_SUB     = 7'b0100000;

  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

endpackage

// File: hdl/id_decoder.sv
// decodes only ADDI ADD SUB LUI and the six branches and marks every other word invalid
`include "id_settings.svh"

module id_decoder (
  input  id_pkg::inst_t     i_inst,
  output id_pkg::gpr_addr_t o_rs1,
  output id_pkg::gpr_addr_t o_rs2,
  output id_pkg::gpr_addr_t o_rd,
  output id_pkg::xdata_t    o_imm,
  output id_pkg::alu_op_e   o_alu_op,
  output id_pkg::src1_sel_e o_src1_sel,
  output id_pkg::src2_sel_e o_src2_sel,
  output logic              o_gpr_wen,
  output logic              o_is_branch,
  output id_pkg::br_func_t  o_br_func,
  output logic              o_invalid_inst
);

  id_pkg::opcode_e opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  id_pkg::xdata_t  imm_i;
  id_pkg::xdata_t  imm_u;
  id_pkg::xdata_t  imm_b;

  assign opcode = id_pkg::opcode_e'(i_inst[6:0]);
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  // raw fields, hazard compare relies on these whatever the format
  assign o_rs1     = i_inst[19:15];
  assign o_rs2     = i_inst[24:20];
  assign o_rd      = i_inst[11:7];
  assign o_br_func = funct3;

  assign imm_i = {{(`ID_XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{(`ID_XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_b = {{(`ID_XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7],
                  i_inst[30:25], i_inst[11:8], 1'b0};

  always_comb begin
    o_imm          = imm_i;
    o_alu_op       = id_pkg::ALU_ADD;
    o_src1_sel     = id_pkg::SRC1_REG;
    o_src2_sel     = id_pkg::SRC2_REG;
    o_gpr_wen      = 1'b0;
    o_is_branch    = 1'b0;
    o_invalid_inst = 1'b0;

    case (opcode)
      id_pkg::OPC_OP_IMM: begin
        if (funct3 == id_pkg::F3_ADD_SUB) begin // addi
          o_src2_sel = id_pkg::SRC2_IMM;
          o_gpr_wen  = 1'b1;
        end else begin
          o_invalid_inst = 1'b1;
        end
      end
      id_pkg::OPC_OP: begin
        if (funct3 == id_pkg::F3_ADD_SUB && funct7 == id_pkg::F7_ADD) begin
          o_gpr_wen = 1'b1;
        end else if (funct3 == id_pkg::F3_ADD_SUB && funct7 == id_pkg::F7_SUB) begin
          o_alu_op  = id_pkg::ALU_SUB;
          o_gpr_wen = 1'b1;
        end else begin
          o_invalid_inst = 1'b1;
        end
      end
      id_pkg::OPC_LUI: begin
        o_imm      = imm_u;
        o_alu_op   = id_pkg::ALU_PASS_B;
        o_src1_sel = id_pkg::SRC1_ZERO;
        o_src2_sel = id_pkg::SRC2_IMM;
        o_gpr_wen  = 1'b1;
      end
      id_pkg::OPC_BRANCH: begin
        o_imm = imm_b;
        case (funct3)
          id_pkg::F3_BEQ,
          id_pkg::F3_BNE,
          id_pkg::F3_BLT,
          id_pkg::F3_BGE,
          id_pkg::F3_BLTU,
          id_pkg::F3_BGEU: o_is_branch = 1'b1;
          default:         o_invalid_inst = 1'b1; // funct3 010 / 011
        endcase
      end
      default: begin
        o_invalid_inst = 1'b1;
      end
    endcase
  end

endmodule

// File: hdl/id_gpr_file.sv
// x0 always reads zero and contents come up undefined since there is no reset or write bypass
`include "id_settings.svh"

module id_gpr_file (
  input  logic              i_clk,
  // read ports
  input  id_pkg::gpr_addr_t i_raddr1,
  output id_pkg::xdata_t    o_rdata1,
  input  id_pkg::gpr_addr_t i_raddr2,
  output id_pkg::xdata_t    o_rdata2,
  // write port from ws
  input  logic              i_wen,
  input  id_pkg::gpr_addr_t i_waddr,
  input  id_pkg::xdata_t    i_wdata
);

  id_pkg::xdata_t regs [`ID_GPR_NUM];

  always_ff @(posedge i_clk) begin
    if (i_wen && i_waddr != '0) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // entry 0 is never written
  always_comb begin
    if (i_raddr1 == '0) begin
      o_rdata1 = '0;
    end else begin
      o_rdata1 = regs[i_raddr1];
    end
    if (i_raddr2 == '0) begin
      o_rdata2 = '0;
    end else begin
      o_rdata2 = regs[i_raddr2];
    end
  end

endmodule

// File: hdl/id_hazard_check.sv
// one destination compare against raw source fields so a format without rs2 may stall needlessly

module id_hazard_check (
  input  id_pkg::gpr_addr_t i_rs1,
  input  id_pkg::gpr_addr_t i_rs2,
  input  id_pkg::gpr_addr_t i_dst,
  output logic              o_stall
);

  logic dst_live;
  logic hit_rs1;
  logic hit_rs2;

  assign dst_live = (i_dst != '0); // x0 never creates a dependency
  assign hit_rs1  = (i_dst == i_rs1);
  assign hit_rs2  = (i_dst == i_rs2);

  assign o_stall = dst_live && (hit_rs1 || hit_rs2);

endmodule

// File: hdl/id_branch_unit.sv
// condition and target only and the caller must qualify the result with its own branch flag

module id_branch_unit (
  input  id_pkg::br_func_t i_br_func,
  input  id_pkg::xdata_t   i_rs1_data,
  input  id_pkg::xdata_t   i_rs2_data,
  input  id_pkg::pc_t      i_pc,
  input  id_pkg::xdata_t   i_imm,
  output logic             o_cond,
  output id_pkg::pc_t      o_target
);

  logic eq;
  logic lt_s;
  logic lt_u;

  assign eq   = (i_rs1_data == i_rs2_data);
  assign lt_s = ($signed(i_rs1_data) < $signed(i_rs2_data));
  assign lt_u = (i_rs1_data < i_rs2_data);

  always_comb begin
    case (i_br_func)
      id_pkg::F3_BEQ:  o_cond = eq;
      id_pkg::F3_BNE:  o_cond = !eq;
      id_pkg::F3_BLT:  o_cond = lt_s;
      id_pkg::F3_BGE:  o_cond = !lt_s;
      id_pkg::F3_BLTU: o_cond = lt_u;
      id_pkg::F3_BGEU: o_cond = !lt_u;
      default:         o_cond = 1'b0;
    endcase
  end

  // b-type imm already has bit 0 clear
  assign o_target = i_pc + i_imm;

endmodule

// File: hdl/id_stage.sv
// single entry decode stage and fetch must drop its own wrong path after o_br_taken
`include "id_settings.svh"

module id_stage (
  input  logic              i_clk,
  input  logic              i_reset,
  // from fs
  input  logic              i_fs_to_ds_valid,
  input  id_pkg::inst_t     i_fs_inst,
  input  id_pkg::pc_t       i_fs_pc,
  output logic              o_ds_allowin,
  // to es
  input  logic              i_es_allowin,
  output logic              o_ds_to_es_valid,
  output id_pkg::xdata_t    o_rs1_data,
  output id_pkg::xdata_t    o_rs2_data,
  output id_pkg::xdata_t    o_imm,
  output id_pkg::pc_t       o_pc,
  output id_pkg::alu_op_e   o_alu_op,
  output id_pkg::src1_sel_e o_src1_sel,
  output id_pkg::src2_sel_e o_src2_sel,
  output id_pkg::gpr_addr_t o_rd,
  output logic              o_gpr_wen,
  output logic              o_invalid_inst,
  // redirect to fs
  output logic              o_br_taken,
  output id_pkg::pc_t       o_br_target,
  // ws register write
  input  logic              i_ws_gpr_wen,
  input  id_pkg::gpr_addr_t i_ws_gpr_waddr,
  input  id_pkg::xdata_t    i_ws_gpr_wdata,
  // downstream destinations
  input  id_pkg::gpr_addr_t i_es_gpr_rd,
  input  id_pkg::gpr_addr_t i_ms_gpr_rd,
  input  id_pkg::gpr_addr_t i_ws_gpr_rd
);

  logic                    ds_valid;
  logic                    ds_ready_go;
  id_pkg::inst_t           ds_inst;
  id_pkg::pc_t             ds_pc;
  id_pkg::gpr_addr_t       rs1;
  id_pkg::gpr_addr_t       rs2;
  logic                    is_branch;
  id_pkg::br_func_t        br_func;
  logic                    br_cond;
  id_pkg::gpr_addr_t       dst_rd [`ID_HAZ_STAGES];
  logic [`ID_HAZ_STAGES-1:0] stall_vec;

  assign ds_ready_go      = ~|stall_vec;
  assign o_ds_allowin     = !ds_valid || (ds_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ds_ready_go && !is_branch;
  // leaves on allowin, one pulse
  assign o_br_taken       = ds_valid && ds_ready_go && i_es_allowin && is_branch && br_cond;
  assign o_pc             = ds_pc;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_to_ds_valid && o_ds_allowin) begin
      ds_inst <= i_fs_inst;
      ds_pc   <= i_fs_pc;
    end
  end

  id_decoder u_decoder (
    .i_inst         (ds_inst),
    .o_rs1          (rs1),
    .o_rs2          (rs2),
    .o_rd           (o_rd),
    .o_imm          (o_imm),
    .o_alu_op       (o_alu_op),
    .o_src1_sel     (o_src1_sel),
    .o_src2_sel     (o_src2_sel),
    .o_gpr_wen      (o_gpr_wen),
    .o_is_branch    (is_branch),
    .o_br_func      (br_func),
    .o_invalid_inst (o_invalid_inst)
  );

  id_gpr_file u_gprs (
    .i_clk    (i_clk),
    .i_raddr1 (rs1),
    .o_rdata1 (o_rs1_data),
    .i_raddr2 (rs2),
    .o_rdata2 (o_rs2_data),
    .i_wen    (i_ws_gpr_wen),
    .i_waddr  (i_ws_gpr_waddr),
    .i_wdata  (i_ws_gpr_wdata)
  );

  assign dst_rd[0] = i_es_gpr_rd;
  assign dst_rd[1] = i_ms_gpr_rd;
  assign dst_rd[2] = i_ws_gpr_rd;

  for (genvar g = 0; g < `ID_HAZ_STAGES; g++) begin : g_haz
    id_hazard_check u_haz (
      .i_rs1   (rs1),
      .i_rs2   (rs2),
      .i_dst   (dst_rd[g]),
      .o_stall (stall_vec[g])
    );
  end

  id_branch_unit u_bru (
    .i_br_func  (br_func),
    .i_rs1_data (o_rs1_data),
    .i_rs2_data (o_rs2_data),
    .i_pc       (ds_pc),
    .i_imm      (o_imm),
    .o_cond     (br_cond),
    .o_target   (o_br_target)
  );

endmodule

// File: tests/id_stage_assert.sv
// handshake properties only, bound to every id_stage and reaching the internal stage valid bit
module id_stage_assert (
  input logic        i_clk,
  input logic        i_reset,
  input logic        i_ds_valid,
  input logic        i_ds_to_es_valid,
  input logic        i_es_allowin,
  input logic        i_br_taken,
  input id_pkg::pc_t i_pc
);

  // a branch never goes on to execute
  a_no_overlap: assert property (@(posedge i_clk) disable iff (i_reset)
    !(i_ds_to_es_valid && i_br_taken))
    else $error("to_es valid and branch redirect are high together");

  a_hold: assert property (@(posedge i_clk) disable iff (i_reset)
    i_ds_to_es_valid && !i_es_allowin |=> i_ds_valid && $stable(i_pc))
    else $error("held instruction changed under back-pressure");

  a_single_pulse: assert property (@(posedge i_clk) disable iff (i_reset)
    i_br_taken |=> !i_br_taken) // stage empties behind a redirect
    else $error("redirect pulse longer than one cycle");

endmodule

bind id_stage id_stage_assert u_id_stage_assert (
  .i_clk            (i_clk),
  .i_reset          (i_reset),
  .i_ds_valid       (ds_valid),
  .i_ds_to_es_valid (o_ds_to_es_valid),
  .i_es_allowin     (i_es_allowin),
  .i_br_taken       (o_br_taken),
  .i_pc             (o_pc)
);

// File: tests/tb_id_stage.sv
// random test that loads every register through ws first and models a fetch dropping its wrong path
`include "id_settings.svh"

module tb_id_stage;

  localparam int CLK_PERIOD = 8;
  localparam int NUM_TXN    = 2000;

  logic              i_clk = 1'b0;
  logic              i_reset, i_fs_to_ds_valid, i_es_allowin, i_ws_gpr_wen;
  id_pkg::inst_t     i_fs_inst;
  id_pkg::pc_t       i_fs_pc, o_pc, o_br_target;
  id_pkg::gpr_addr_t i_ws_gpr_waddr, i_es_gpr_rd, i_ms_gpr_rd, i_ws_gpr_rd, o_rd;
  id_pkg::xdata_t    i_ws_gpr_wdata, o_rs1_data, o_rs2_data, o_imm;
  logic              o_ds_allowin, o_ds_to_es_valid, o_gpr_wen, o_invalid_inst, o_br_taken;
  id_pkg::alu_op_e   o_alu_op;
  id_pkg::src1_sel_e o_src1_sel;
  id_pkg::src2_sel_e o_src2_sel;

  int                seed = 96249;
  int                hs_count = 0;
  int                nonbr_count = 0;
  int                accepted = 0;
  logic              draining = 1'b0;
  id_pkg::xdata_t    mirror [`ID_GPR_NUM];
  id_pkg::inst_t     inst_q [$]; // holds at most the one instruction in the stage
  id_pkg::pc_t       pc_q [$];

  typedef struct packed {
    id_pkg::xdata_t  imm;
    logic            has_imm;
    id_pkg::alu_op_e alu_op;
    logic            src1_zero;
    logic            src2_imm;
    logic            wen;
    logic            is_br;
    logic            invalid;
  } dec_t;

  id_stage id_stage_i (.*);

  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  task automatic stop_on_error(string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_xdata(string name, id_pkg::xdata_t got, id_pkg::xdata_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("** Error at %0t: %s expected %h got %h", $time, name, exp, got));
    end
  endtask

  task automatic check_pc(string name, id_pkg::pc_t got, id_pkg::pc_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("** Error at %0t: %s expected %h got %h", $time, name, exp, got));
    end
  endtask

  task automatic check_addr(string name, id_pkg::gpr_addr_t got, id_pkg::gpr_addr_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("** Error at %0t: %s expected x%0d got x%0d", $time, name, exp, got));
    end
  endtask

  task automatic check_alu_op(string name, id_pkg::alu_op_e got, id_pkg::alu_op_e exp);
    if (got !== exp) begin
      stop_on_error($sformatf("** Error at %0t: %s expected %0d got %0d", $time, name, exp, got));
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      stop_on_error($sformatf("** Error at %0t: %s expected %b got %b", $time, name, exp, got));
    end
  endtask

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  // reference decode from the RV64I encodings of the kept subset
  function automatic dec_t decode_model(id_pkg::inst_t w);
    dec_t d;
    d         = '0;
    d.invalid = 1'b1;
    case (w[6:0])
      7'b0010011: begin // addi
        d.invalid  = (w[14:12] != 3'b000);
        d.wen      = !d.invalid;
        d.imm      = {{52{w[31]}}, w[31:20]};
        d.has_imm  = 1'b1;
        d.src2_imm = 1'b1;
      end
      7'b0110011: begin
        d.invalid = (w[14:12] != 3'b000) || (w[31:25] != 7'b0000000 && w[31:25] != 7'b0100000);
        d.wen     = !d.invalid;
        if (w[30]) begin
          d.alu_op = id_pkg::ALU_SUB;
        end
      end
      7'b0110111: begin // lui
        d.invalid   = 1'b0;
        d.wen       = 1'b1;
        d.imm       = {{32{w[31]}}, w[31:12], 12'b0};
        d.has_imm   = 1'b1;
        d.alu_op    = id_pkg::ALU_PASS_B;
        d.src1_zero = 1'b1;
        d.src2_imm  = 1'b1;
      end
      7'b1100011: begin
        d.invalid = (w[14:13] == 2'b01); // funct3 010 and 011 are not branches
        d.is_br   = !d.invalid;
        d.imm     = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        d.has_imm = 1'b1;
      end
      default: ;
    endcase
    return d;
  endfunction

  function automatic logic cond_model(logic [2:0] f3, id_pkg::xdata_t a, id_pkg::xdata_t b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic hits(id_pkg::inst_t w, id_pkg::gpr_addr_t rd);
    return rd != 5'd0 && (rd == w[19:15] || rd == w[24:20]);
  endfunction

  function automatic logic redirect_model(id_pkg::gpr_addr_t e, id_pkg::gpr_addr_t m,
                                          id_pkg::gpr_addr_t v, logic es_in);
    id_pkg::inst_t w;
    dec_t          d;
    if (inst_q.size() == 0) begin
      return 1'b0;
    end
    w = inst_q[0];
    d = decode_model(w);
    return d.is_br && es_in && !(hits(w, e) || hits(w, m) || hits(w, v))
           && cond_model(w[14:12], mirror[w[19:15]], mirror[w[24:20]]);
  endfunction

  function automatic id_pkg::inst_t gen_inst();
    logic [31:0] w;
    logic [31:0] r;
    w = rand32();
    r = rand32();
    case (r[2:0])
      3'd0: w[14:0] = {3'b000, w[11:7], 7'b0010011};
      3'd1, 3'd2: begin // sub when r[0] is set
        w[31:25] = {1'b0, r[0], 5'b0};
        w[14:0]  = {3'b000, w[11:7], 7'b0110011};
      end
      3'd3: w[6:0] = 7'b0110111;
      3'd4, 3'd5: begin
        w[14:12] = (r[5:4] == 2'b01) ? {2'b00, r[3]} : r[5:3];
        w[6:0]   = 7'b1100011;
        if (r[0]) begin
          w[24:20] = w[19:15]; // equal operands
        end
      end
      default: ; // raw random word
    endcase
    return w;
  endfunction

  // mostly x0, sometimes a source of the held instruction
  function automatic id_pkg::gpr_addr_t pick_rd(id_pkg::inst_t w);
    logic [31:0] r;
    r = rand32();
    case (r[3:0])
      4'd13:   return w[19:15];
      4'd14:   return w[24:20];
      4'd15:   return r[8:4];
      default: return 5'd0;
    endcase
  endfunction

  task automatic drive_inputs();
    logic [31:0]       r;
    logic [31:0]       pc_lo;
    id_pkg::inst_t     held;
    id_pkg::gpr_addr_t e, m, v;
    logic              es_in;
    r     = rand32();
    pc_lo = rand32();
    held  = (inst_q.size() != 0) ? inst_q[0] : rand32();
    e     = draining ? 5'd0 : pick_rd(held);
    m     = draining ? 5'd0 : pick_rd(held);
    v     = draining ? 5'd0 : pick_rd(held);
    es_in = draining || r[1:0] != 2'b00;
    i_es_gpr_rd      <= e;
    i_ms_gpr_rd      <= m;
    i_ws_gpr_rd      <= v;
    i_es_allowin     <= es_in;
    i_fs_to_ds_valid <= !draining && r[3:2] != 2'b00 && !redirect_model(e, m, v, es_in);
    i_fs_inst        <= gen_inst();
    i_fs_pc          <= {rand32(), pc_lo[31:2], 2'b00};
    i_ws_gpr_wen     <= r[4];
    i_ws_gpr_waddr   <= r[9:5];
    i_ws_gpr_wdata   <= (r[11:10] == 2'b00) ? {62'b0, r[13:12]} : {rand32(), rand32()};
  endtask

  task automatic check_cycle();
    dec_t          d;
    id_pkg::inst_t w;
    logic          valid, ready, allowin, br;
    valid   = inst_q.size() != 0;
    w       = valid ? inst_q[0] : '0;
    d       = decode_model(w);
    ready   = !(hits(w, i_es_gpr_rd) || hits(w, i_ms_gpr_rd) || hits(w, i_ws_gpr_rd));
    allowin = !valid || (ready && i_es_allowin);
    br      = redirect_model(i_es_gpr_rd, i_ms_gpr_rd, i_ws_gpr_rd, i_es_allowin);
    check_bit("o_ds_allowin", o_ds_allowin, allowin);
    check_bit("o_ds_to_es_valid", o_ds_to_es_valid, valid && ready && !d.is_br);
    check_bit("o_br_taken", o_br_taken, br);
    if (valid) begin
      check_pc("o_pc", o_pc, pc_q[0]);
      check_addr("o_rd", o_rd, w[11:7]);
      check_bit("o_gpr_wen", o_gpr_wen, d.wen);
      check_bit("o_invalid_inst", o_invalid_inst, d.invalid);
      check_xdata("o_rs1_data", o_rs1_data, mirror[w[19:15]]);
      check_xdata("o_rs2_data", o_rs2_data, mirror[w[24:20]]);
      if (d.has_imm && !d.invalid) begin
        check_xdata("o_imm", o_imm, d.imm);
      end
      if (!d.invalid && !d.is_br) begin
        check_alu_op("o_alu_op", o_alu_op, d.alu_op);
        check_bit("o_src1_sel", o_src1_sel, d.src1_zero);
        check_bit("o_src2_sel", o_src2_sel, d.src2_imm);
      end
    end
    if (br) begin
      check_pc("o_br_target", o_br_target, pc_q[0] + d.imm);
    end
    // handshakes seen on the dut side
    if (o_ds_to_es_valid && i_es_allowin) begin
      hs_count++;
    end
    // model state after the coming edge
    if (valid && ready && i_es_allowin) begin
      void'(inst_q.pop_front());
      void'(pc_q.pop_front());
    end
    if (i_fs_to_ds_valid && allowin) begin
      inst_q.push_back(i_fs_inst);
      pc_q.push_back(i_fs_pc);
      accepted++;
      d = decode_model(i_fs_inst);
      if (!d.is_br) begin
        nonbr_count++;
      end
    end
    if (i_ws_gpr_wen && i_ws_gpr_waddr != 5'd0) begin
      mirror[i_ws_gpr_waddr] = i_ws_gpr_wdata;
    end
  endtask

  initial begin
    i_reset          <= 1'b1;
    i_fs_to_ds_valid <= 1'b0;
    i_fs_inst        <= '0;
    i_fs_pc          <= '0;
    i_es_allowin     <= 1'b1;
    i_ws_gpr_wen     <= 1'b0;
    i_ws_gpr_waddr   <= '0;
    i_ws_gpr_wdata   <= '0;
    i_es_gpr_rd      <= '0;
    i_ms_gpr_rd      <= '0;
    i_ws_gpr_rd      <= '0;
    mirror[0] = '0;
    repeat (5) @(posedge i_clk);
    i_reset <= 1'b0;
    @(negedge i_clk);
    check_bit("o_ds_to_es_valid", o_ds_to_es_valid, 1'b0);
    check_bit("o_br_taken", o_br_taken, 1'b0);
    check_bit("o_ds_allowin", o_ds_allowin, 1'b1);
    for (int i = 1; i < `ID_GPR_NUM; i++) begin
      @(posedge i_clk);
      i_ws_gpr_wen   <= 1'b1;
      i_ws_gpr_waddr <= 5'(i);
      i_ws_gpr_wdata <= {rand32(), rand32()};
      @(negedge i_clk);
      check_cycle();
    end
    while (accepted < NUM_TXN) begin
      @(posedge i_clk);
      drive_inputs();
      @(negedge i_clk);
      check_cycle();
    end
    draining = 1'b1;
    while (inst_q.size() != 0) begin
      @(posedge i_clk);
      drive_inputs();
      @(negedge i_clk);
      check_cycle();
    end
    if (hs_count != nonbr_count) begin
      stop_on_error($sformatf("%0d instructions reached execute but %0d non-branches were accepted",
                              hs_count, nonbr_count));
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

  // 20 cycles per transaction plus reset and register load
  initial begin
    #((NUM_TXN * 20 + 100) * CLK_PERIOD);
    stop_on_error("timeout: the run did not complete within the expected time");
  end

endmodule

// File: build.f
+incdir+hdl
hdl/id_pkg.sv
hdl/id_decoder.sv
hdl/id_gpr_file.sv
hdl/id_hazard_check.sv
hdl/id_branch_unit.sv
hdl/id_stage.sv
tests/id_stage_assert.sv
tests/tb_id_stage.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_id_stage
FILELIST = build.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
